/* common/gmii_pkg.sv */
// GMII line definitions
`default_nettype none

package gmii_pkg;

    // Line bytes ahead of the frame data
    localparam logic [7:0] GMII_PREAMBLE = 8'h55;
    localparam logic [7:0] GMII_SFD      = 8'hD5;

    // Preamble bytes sent before the SFD
    localparam int PREAMBLE_LEN = 7;

    // Receive deframer states
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_PREAMBLE,
        RX_DATA,
        RX_DISCARD
    } rx_state_e;

    // Transmit framer states
    typedef enum logic [2:0] {
        TX_IDLE,
        TX_PREAMBLE,
        TX_SFD,
        TX_DATA,
        TX_GAP
    } tx_state_e;

endpackage

`default_nettype wire

/* common/frame_pkg.sv */
// Frame buffering definitions
`default_nettype none

package frame_pkg;

    // Byte count of one frame after the SFD
    typedef logic [15:0] frame_len_t;

    // Wrapping frame counter as wide as one LED nibble
    typedef logic [3:0] frame_cnt_t;

    // Smallest legal frame with the FCS included
    localparam frame_len_t MIN_FRAME_LEN = 16'd64;

endpackage

`default_nettype wire

/* rtl/gmii_rx_deframer.sv */
// GMII receive deframer
`timescale 1ns/100ps
`default_nettype none

module gmii_rx_deframer
    import gmii_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       arst_n,
    input  wire logic [7:0] gmii_rxd,
    input  wire logic       gmii_rx_dv,
    input  wire logic       gmii_rx_er,
    output logic      [7:0] rx_data,
    output logic            rx_valid,
    output logic            rx_last,
    output logic            rx_bad
);

    rx_state_e state;

    logic [7:0] rxd_q;
    logic       dv_q;
    logic       er_q;
    logic [7:0] hold_data;
    logic       hold_valid;
    logic       err_flag;

    // Input register and byte pipeline
    always_ff @(posedge clk) begin
        rxd_q <= gmii_rxd;
        if (state == RX_DATA && dv_q) begin
            hold_data <= rxd_q;
        end
        rx_data <= hold_data;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= RX_IDLE;
            dv_q       <= 1'b0;
            er_q       <= 1'b0;
            hold_valid <= 1'b0;
            err_flag   <= 1'b0;
            rx_valid   <= 1'b0;
            rx_last    <= 1'b0;
            rx_bad     <= 1'b0;
        end else begin
            dv_q <= gmii_rx_dv;
            er_q <= gmii_rx_er;

            // Held byte is last when no further byte followed it
            rx_valid <= hold_valid;
            rx_last  <= hold_valid && !dv_q;
            rx_bad   <= err_flag;

            hold_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (dv_q) begin
                        err_flag <= er_q;
                        if (rxd_q == GMII_SFD) begin
                            state <= RX_DATA;
                        end else if (rxd_q == GMII_PREAMBLE) begin
                            state <= RX_PREAMBLE;
                        end else begin
                            state <= RX_DISCARD;
                        end
                    end
                end
                RX_PREAMBLE: begin
                    if (!dv_q) begin
                        // Carrier lost before the SFD
                        state <= RX_IDLE;
                    end else begin
                        err_flag <= err_flag | er_q;
                        if (rxd_q == GMII_SFD) begin
                            state <= RX_DATA;
                        end else if (rxd_q != GMII_PREAMBLE) begin
                            state <= RX_DISCARD;
                        end
                    end
                end
                RX_DATA: begin
                    if (!dv_q) begin
                        state <= RX_IDLE;
                    end else begin
                        hold_valid <= 1'b1;
                        err_flag   <= err_flag | er_q;
                    end
                end
                default: begin
                    // Wait out a burst with a broken preamble
                    if (!dv_q) begin
                        state <= RX_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* frame_fifo/frame_fifo.sv */
// Store-and-forward frame FIFO
`timescale 1ns/100ps
`default_nettype none

module frame_fifo
    import frame_pkg::*;
#(
    parameter int FIFO_DEPTH    = 2048,
    parameter int MAX_FRAME_LEN = 1518
) (
    input  wire logic       clk,
    input  wire logic       arst_n,
    input  wire logic [7:0] rx_data,
    input  wire logic       rx_valid,
    input  wire logic       rx_last,
    input  wire logic       rx_bad,
    input  wire logic       frame_req,
    output logic            frame_avail,
    output logic      [7:0] out_data,
    output logic            out_valid,
    output logic            out_last,
    output frame_cnt_t      good_count,
    output frame_cnt_t      drop_count
);

    localparam int AW = $clog2(FIFO_DEPTH);

    // Stored word is {last, data}
    logic [8:0] mem [FIFO_DEPTH];

    logic [AW:0] wr_ptr;
    logic [AW:0] wr_commit;
    logic [AW:0] rd_ptr;
    logic [AW:0] frame_count;
    frame_len_t  frame_len;
    frame_len_t  len_total;
    logic        hit_full;
    logic        full;
    logic        wr_en;
    logic        commit;
    logic        rd_en;
    logic        reading;

    assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign wr_en = rx_valid && !full;
    assign len_total = frame_len + 16'd1;

    // Keep the frame only if it is clean, in range and fully stored
    assign commit = rx_valid && rx_last && !rx_bad && !hit_full && !full
        && (len_total >= MIN_FRAME_LEN)
        && (len_total <= frame_len_t'(MAX_FRAME_LEN));

    // Read from the request until the stored last byte has gone out
    assign rd_en = frame_req || (reading && !(out_valid && out_last));

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= {rx_last, rx_data};
        end
        if (rd_en) begin
            {out_last, out_data} <= mem[rd_ptr[AW-1:0]];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr      <= '0;
            wr_commit   <= '0;
            rd_ptr      <= '0;
            frame_count <= '0;
            frame_len   <= '0;
            hit_full    <= 1'b0;
            reading     <= 1'b0;
            frame_avail <= 1'b0;
            out_valid   <= 1'b0;
            good_count  <= '0;
            drop_count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rx_valid) begin
                if (rx_last) begin
                    frame_len <= '0;
                    hit_full  <= 1'b0;
                    if (commit) begin
                        wr_commit  <= wr_ptr + 1'b1;
                        good_count <= good_count + 1'b1;
                    end else begin
                        // Rewind over the partial frame
                        wr_ptr     <= wr_commit;
                        drop_count <= drop_count + 1'b1;
                    end
                end else begin
                    frame_len <= len_total;
                    hit_full  <= hit_full | full;
                end
            end

            case ({commit, frame_req})
                2'b10:   frame_count <= frame_count + 1'b1;
                2'b01:   frame_count <= frame_count - 1'b1;
                default: frame_count <= frame_count;
            endcase
            frame_avail <= (frame_count != '0);

            out_valid <= rd_en;
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (frame_req) begin
                reading <= 1'b1;
            end else if (out_valid && out_last) begin
                reading <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/gmii_tx_framer.sv */
// GMII transmit framer
`timescale 1ns/100ps
`default_nettype none

module gmii_tx_framer
    import gmii_pkg::*;
#(
    parameter int TX_IFG = 12
) (
    input  wire logic       clk,
    input  wire logic       arst_n,
    input  wire logic       frame_avail,
    input  wire logic [7:0] out_data,
    input  wire logic       out_valid,
    input  wire logic       out_last,
    output logic            frame_req,
    output logic      [7:0] gmii_txd,
    output logic            gmii_tx_en
);

    // Counter covers both the preamble and the gap
    localparam int CNT_MAX = (TX_IFG > PREAMBLE_LEN) ? TX_IFG : PREAMBLE_LEN;
    localparam int CW      = $clog2(CNT_MAX + 1);

    tx_state_e state;

    logic [CW-1:0] cnt;

    // Ask the FIFO for data while the SFD is on the line
    assign frame_req = (state == TX_SFD);

    always_comb begin
        case (state)
            TX_PREAMBLE: begin
                gmii_txd   = GMII_PREAMBLE;
                gmii_tx_en = 1'b1;
            end
            TX_SFD: begin
                gmii_txd   = GMII_SFD;
                gmii_tx_en = 1'b1;
            end
            TX_DATA: begin
                gmii_txd   = out_data;
                gmii_tx_en = out_valid;
            end
            default: begin
                gmii_txd   = 8'h00;
                gmii_tx_en = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= TX_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (frame_avail) begin
                        state <= TX_PREAMBLE;
                        cnt   <= '0;
                    end
                end
                TX_PREAMBLE: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CW'(PREAMBLE_LEN - 1)) begin
                        state <= TX_SFD;
                    end
                end
                TX_SFD: begin
                    state <= TX_DATA;
                end
                TX_DATA: begin
                    if (out_valid && out_last) begin
                        state <= TX_GAP;
                        cnt   <= '0;
                    end
                end
                default: begin
                    // TX_IFG idle cycles of inter-frame gap
                    cnt <= cnt + 1'b1;
                    if (cnt == CW'(TX_IFG - 1)) begin
                        state <= TX_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/fpga_core.sv */
// GMII frame loopback core
`timescale 1ns/100ps
`default_nettype none

module fpga_core
    import frame_pkg::*;
#(
    parameter int MAX_FRAME_LEN = 1518,
    parameter int FIFO_DEPTH    = 2048,
    parameter int TX_IFG        = 12
) (
    input  wire logic       clk,
    input  wire logic       arst_n,
    input  wire logic [7:0] gmii_rxd,
    input  wire logic       gmii_rx_dv,
    input  wire logic       gmii_rx_er,
    output logic      [7:0] gmii_txd,
    output logic            gmii_tx_en,
    output logic      [7:0] led
);

    logic [7:0] rx_data;
    logic       rx_valid;
    logic       rx_last;
    logic       rx_bad;
    logic       frame_avail;
    logic       frame_req;
    logic [7:0] out_data;
    logic       out_valid;
    logic       out_last;
    frame_cnt_t good_count;
    frame_cnt_t drop_count;

    // Dropped frames high, forwarded frames low
    assign led = {drop_count, good_count};

    gmii_rx_deframer rx_deframer_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .gmii_rxd   (gmii_rxd),
        .gmii_rx_dv (gmii_rx_dv),
        .gmii_rx_er (gmii_rx_er),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .rx_last    (rx_last),
        .rx_bad     (rx_bad)
    );

    frame_fifo #(
        .FIFO_DEPTH    (FIFO_DEPTH),
        .MAX_FRAME_LEN (MAX_FRAME_LEN)
    ) frame_fifo_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .rx_last     (rx_last),
        .rx_bad      (rx_bad),
        .frame_req   (frame_req),
        .frame_avail (frame_avail),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .out_last    (out_last),
        .good_count  (good_count),
        .drop_count  (drop_count)
    );

    gmii_tx_framer #(
        .TX_IFG (TX_IFG)
    ) tx_framer_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .frame_avail (frame_avail),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .out_last    (out_last),
        .frame_req   (frame_req),
        .gmii_txd    (gmii_txd),
        .gmii_tx_en  (gmii_tx_en)
    );

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
// Testbench clock and reset
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk = ~clk;
        end
    end

    // Release reset just after a rising edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* verification/fpga_core_assertions.sv */
// Loopback core output assertions
`timescale 1ns/100ps
`default_nettype none

module fpga_core_assertions
    import gmii_pkg::*;
#(
    parameter int TX_IFG = 12
) (
    input wire logic       clk,
    input wire logic       arst_n,
    input wire logic [7:0] gmii_txd,
    input wire logic       gmii_tx_en
);

    // Saturating count of idle cycles since gmii_tx_en was last high
    logic [15:0] idle_run;
    int          fail_count = 0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idle_run <= '1;
        end else if (gmii_tx_en) begin
            idle_run <= '0;
        end else if (idle_run != '1) begin
            idle_run <= idle_run + 16'd1;
        end
    end

    tx_idle_in_reset: assert property (@(posedge clk) !arst_n |-> !gmii_tx_en)
        else begin
            fail_count++;
            $error("gmii_tx_en is high during reset");
        end

    burst_starts_with_preamble: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(gmii_tx_en) |-> (gmii_txd == GMII_PREAMBLE))
        else begin
            fail_count++;
            $error("gmii_tx_en burst starts with 0x%02h", gmii_txd);
        end

    // Low cycles ahead of a new burst cover the gap
    gap_kept: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(gmii_tx_en) |-> (idle_run >= 16'(TX_IFG)))
        else begin
            fail_count++;
            $error("Inter-frame gap of %0d cycles is too short", idle_run);
        end

endmodule

bind fpga_core fpga_core_assertions #(
    .TX_IFG (TX_IFG)
) assertions_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .gmii_txd   (gmii_txd),
    .gmii_tx_en (gmii_tx_en)
);

`default_nettype wire

/* verification/tb_fpga_core.sv */
// Loopback core testbench
`timescale 1ns/100ps
`default_nettype none

module tb_fpga_core
    import gmii_pkg::*;
    import frame_pkg::*;
();

    localparam int MAX_FRAME_LEN  = 240;
    localparam int FIFO_DEPTH     = 256;
    localparam int TX_IFG         = 12;
    // Generous bound over the traffic of all tests
    localparam int TIMEOUT_CYCLES = 40000;
    localparam int DRIVE_DELAY    = 10;
    localparam int QUIET_CYCLES   = 40;
    localparam int MAX_SENT       = 8;
    localparam int MAX_CAPTURE    = 32;
    localparam int MAX_BYTES      = 320;

    logic       clk;
    logic       arst_n;
    logic [7:0] gmii_rxd;
    logic       gmii_rx_dv;
    logic       gmii_rx_er;
    logic [7:0] gmii_txd;
    logic       gmii_tx_en;
    logic [7:0] led;

    // Payloads sent, and bursts seen on the transmit side
    logic [7:0] sent_data [MAX_SENT][MAX_BYTES];
    int         sent_len  [MAX_SENT];
    logic [7:0] cap_data  [MAX_CAPTURE][MAX_BYTES];
    int         cap_len   [MAX_CAPTURE];
    int         cap_count = 0;
    int         burst_len = 0;

    int check_count = 0;
    int error_count = 0;
    int cycle_count = 0;

    tb_clock_gen #(
        .PERIOD_NS    (100),
        .RESET_CYCLES (2)
    ) clock_gen_inst (
        .clk    (clk),
        .arst_n (arst_n)
    );

    fpga_core #(
        .MAX_FRAME_LEN (MAX_FRAME_LEN),
        .FIFO_DEPTH    (FIFO_DEPTH),
        .TX_IFG        (TX_IFG)
    ) UUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .gmii_rxd   (gmii_rxd),
        .gmii_rx_dv (gmii_rx_dv),
        .gmii_rx_er (gmii_rx_er),
        .gmii_txd   (gmii_txd),
        .gmii_tx_en (gmii_tx_en),
        .led        (led)
    );

    // Collect every gmii_tx_en burst by sampling mid-cycle
    always @(negedge clk) begin
        if (gmii_tx_en) begin
            if (cap_count < MAX_CAPTURE && burst_len < MAX_BYTES) begin
                cap_data[cap_count][burst_len] = gmii_txd;
            end
            burst_len++;
        end else if (burst_len != 0) begin
            if (cap_count < MAX_CAPTURE) begin
                cap_len[cap_count] = burst_len;
            end
            cap_count++;
            burst_len = 0;
        end
    end

    task automatic report_and_finish();
        int total;
        total = error_count + UUT.assertions_inst.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, UUT.assertions_inst.fail_count);
        if (total == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        error_count++;
        $display("Run stopped by the timeout after %0d cycles", cycle_count);
        report_and_finish();
    end

    task automatic compare_frame(input string name, input int slot, input int cap);
        int         exp_len;
        logic [7:0] exp_byte;
        exp_len = sent_len[slot] + PREAMBLE_LEN + 1;
        check_count++;
        if (cap >= MAX_CAPTURE) begin
            error_count++;
            $display("%s: more bursts appeared than the capture buffer can hold", name);
            return;
        end
        if (cap_len[cap] != exp_len) begin
            error_count++;
            $display("FAIL %s length: expected %0d, actual %0d", name, exp_len, cap_len[cap]);
            return;
        end
        for (int i = 0; i < exp_len; i++) begin
            if (i < PREAMBLE_LEN) begin
                exp_byte = GMII_PREAMBLE;
            end else if (i == PREAMBLE_LEN) begin
                exp_byte = GMII_SFD;
            end else begin
                exp_byte = sent_data[slot][i - PREAMBLE_LEN - 1];
            end
            if (cap_data[cap][i] !== exp_byte) begin
                error_count++;
                $display("FAIL %s byte %0d: expected 0x%02h, actual 0x%02h",
                         name, i, exp_byte, cap_data[cap][i]);
                return;
            end
        end
    endtask

    task automatic compare_count(input string name, input frame_cnt_t expected,
                                 input frame_cnt_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic expect_bursts(input string name, input int first, input int expected);
        check_count++;
        if (cap_count - first != expected) begin
            error_count++;
            $display("FAIL %s bursts: expected %0d, actual %0d",
                     name, expected, cap_count - first);
        end
    endtask

    function automatic bit frame_matches(input int slot, input int cap);
        if (cap_len[cap] != sent_len[slot] + PREAMBLE_LEN + 1) begin
            return 1'b0;
        end
        for (int i = 0; i < sent_len[slot]; i++) begin
            if (cap_data[cap][i + PREAMBLE_LEN + 1] !== sent_data[slot][i]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic drive_byte(input logic [7:0] data, input logic dv, input logic er);
        @(posedge clk);
        #DRIVE_DELAY;
        gmii_rxd   = data;
        gmii_rx_dv = dv;
        gmii_rx_er = er;
    endtask

    task automatic fill_payload(input int slot, input int len);
        sent_len[slot] = len;
        for (int i = 0; i < len; i++) begin
            sent_data[slot][i] = 8'($urandom);
        end
    endtask

    // Preamble with an optional bad byte, optional SFD, payload, then idle
    task automatic send_burst(input int slot, input int err_at, input int bad_pos,
                              input bit with_sfd, input int gap);
        for (int i = 0; i < PREAMBLE_LEN; i++) begin
            drive_byte((i == bad_pos) ? 8'h3c : GMII_PREAMBLE, 1'b1, 1'b0);
        end
        if (with_sfd) begin
            drive_byte(GMII_SFD, 1'b1, 1'b0);
        end
        for (int i = 0; i < sent_len[slot]; i++) begin
            drive_byte(sent_data[slot][i], 1'b1, i == err_at);
        end
        for (int i = 0; i < gap; i++) begin
            drive_byte(8'h00, 1'b0, 1'b0);
        end
    endtask

    task automatic wait_bursts(input int count);
        while (cap_count < count) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_drops(input frame_cnt_t target);
        while (led[7:4] != target) begin
            @(negedge clk);
        end
    endtask

    // Both GMII sides idle for a while
    task automatic wait_quiet();
        int quiet;
        quiet = 0;
        while (quiet < QUIET_CYCLES) begin
            @(negedge clk);
            quiet = (gmii_tx_en || gmii_rx_dv) ? 0 : quiet + 1;
        end
    endtask

    task automatic test_reset();
        check_count++;
        if (gmii_tx_en !== 1'b0) begin
            error_count++;
            $display("FAIL reset gmii_tx_en: expected 0, actual %0b", gmii_tx_en);
        end
        compare_count("reset good count", 4'd0, led[3:0]);
        compare_count("reset drop count", 4'd0, led[7:4]);
    endtask

    task automatic test_good_frames();
        int         first;
        frame_cnt_t good0;
        first = cap_count;
        good0 = led[3:0];
        fill_payload(0, 64);
        fill_payload(1, 100);
        fill_payload(2, 240);
        for (int s = 0; s < 3; s++) begin
            send_burst(s, -1, -1, 1'b1, 16);
        end
        wait_bursts(first + 3);
        wait_quiet();
        expect_bursts("good frames", first, 3);
        for (int s = 0; s < 3; s++) begin
            compare_frame($sformatf("good frame %0d", s), s, first + s);
        end
        compare_count("good frames good count", frame_cnt_t'(good0 + 3), led[3:0]);
    endtask

    task automatic test_rx_error();
        int         first;
        frame_cnt_t good0;
        frame_cnt_t drop0;
        first = cap_count;
        good0 = led[3:0];
        drop0 = led[7:4];
        fill_payload(0, 100);
        send_burst(0, 37, -1, 1'b1, 16);
        wait_drops(frame_cnt_t'(drop0 + 1));
        wait_quiet();
        expect_bursts("rx error", first, 0);
        compare_count("rx error good count", good0, led[3:0]);
        compare_count("rx error drop count", frame_cnt_t'(drop0 + 1), led[7:4]);
    endtask

    task automatic test_length_limits();
        int         first;
        frame_cnt_t good0;
        frame_cnt_t drop0;
        first = cap_count;
        good0 = led[3:0];
        drop0 = led[7:4];
        fill_payload(0, 63);
        fill_payload(1, MAX_FRAME_LEN + 1);
        send_burst(0, -1, -1, 1'b1, 16);
        send_burst(1, -1, -1, 1'b1, 16);
        wait_drops(frame_cnt_t'(drop0 + 2));
        wait_quiet();
        expect_bursts("length limits", first, 0);
        compare_count("length limits good count", good0, led[3:0]);
        compare_count("length limits drop count", frame_cnt_t'(drop0 + 2), led[7:4]);
    endtask

    task automatic test_bad_preamble();
        int         first;
        frame_cnt_t good0;
        frame_cnt_t drop0;
        first = cap_count;
        good0 = led[3:0];
        drop0 = led[7:4];
        fill_payload(0, 80);
        fill_payload(1, 0);
        send_burst(0, -1, 3, 1'b1, 16);
        // Carrier drops after the preamble and before any SFD
        send_burst(1, -1, -1, 1'b0, 16);
        wait_quiet();
        expect_bursts("bad preamble", first, 0);
        compare_count("bad preamble good count", good0, led[3:0]);
        compare_count("bad preamble drop count", drop0, led[7:4]);
    endtask

    task automatic test_overload();
        int         first;
        int         slot;
        frame_cnt_t good0;
        frame_cnt_t drop0;
        first = cap_count;
        good0 = led[3:0];
        drop0 = led[7:4];
        for (int s = 0; s < MAX_SENT; s++) begin
            fill_payload(s, 200);
        end
        for (int s = 0; s < MAX_SENT; s++) begin
            send_burst(s, -1, -1, 1'b1, 1);
        end
        wait_quiet();

        // Each burst must match a later sent frame in order
        slot = 0;
        for (int c = first; c < cap_count && c < MAX_CAPTURE; c++) begin
            while (slot < MAX_SENT && !frame_matches(slot, c)) begin
                slot++;
            end
            if (slot == MAX_SENT) begin
                check_count++;
                error_count++;
                $display("overload: burst %0d matches no remaining sent frame", c - first);
            end else begin
                compare_frame($sformatf("overload frame %0d", slot), slot, c);
                slot++;
            end
        end
        compare_count("overload good count", frame_cnt_t'(cap_count - first),
                      led[3:0] - good0);
        compare_count("overload decided frames", 4'd8, (led[3:0] - good0) + (led[7:4] - drop0));
        check_count++;
        if (led[7:4] == drop0) begin
            error_count++;
            $display("overload: no frame was dropped");
        end
    endtask

    initial begin
        gmii_rxd   = 8'h00;
        gmii_rx_dv = 1'b0;
        gmii_rx_er = 1'b0;
        void'($urandom(32'h3cbd_d9fe));
        wait (arst_n === 1'b1);
        @(negedge clk);
        test_reset();
        test_good_frames();
        test_rx_error();
        test_length_limits();
        test_bad_preamble();
        test_overload();
        report_and_finish();
    end

endmodule

`default_nettype wire

/* gmii_loopback.f */
common/gmii_pkg.sv
common/frame_pkg.sv
rtl/gmii_rx_deframer.sv
frame_fifo/frame_fifo.sv
rtl/gmii_tx_framer.sv
rtl/fpga_core.sv
verification/tb_clock_gen.sv
verification/fpga_core_assertions.sv
verification/tb_fpga_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the loopback testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fpga_core \
    -f gmii_loopback.f \
    -o Vtb_fpga_core

./obj_dir/Vtb_fpga_core +verilator+error+limit+100 | tee "$LOG"

if grep -q "Some tests failed" "$LOG"; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation finished without failures"
